//--- cache_lookup.f
+incdir+design
design/cache_pkg.sv
design/sync_ram.sv
design/req_stage.sv
design/hit_check.sv
design/cache_top.sv
tb/cache_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the cache lookup testbench with Verilator, run it, judge the log
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert --timing --timescale 1ns/100ps \
    --top-module cache_tb \
    -Mdir "$BUILD_DIR" -o cache_tb \
    -f cache_lookup.f

"./$BUILD_DIR/cache_tb" | tee "$LOG"

if grep -qx "No errors" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi

//--- tb/cache_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_defs.svh"

module cache_tb import cache_pkg::*; ();

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 5;
    // negedges from driving req to seeing resp_valid for two cycles of latency
    localparam int RESP_DELAY   = 3;
    localparam int RESP_LIMIT   = 10;
    localparam int WORDS        = `CACHE_LINE_BYTES * 8 / `CACHE_WORD_W;
    // single reads and fill or inval commands over all tests plus the burst of test 6
    localparam int SEQ_READS    = 46;
    localparam int WRITES       = 9;
    localparam int PIPE_READS   = 48;
    localparam int RUN_CYCLES   = RESET_CYCLES + SEQ_READS * RESP_DELAY + WRITES
                                  + PIPE_READS + RESP_LIMIT;
    localparam int TIMEOUT_NS   = (RUN_CYCLES + 200) * CLK_PERIOD;

    // lines used by the directed tests
    localparam tag_t   TAG_A = 20'h3_a5c1;
    localparam tag_t   TAG_B = 20'h3_5531;
    localparam tag_t   TAG_C = 20'h0_7e21;
    localparam index_t IDX_A = 6'd9;
    localparam index_t IDX_C = 6'd20;

    logic                     clk;
    logic                     reset;
    logic                     req;
    logic [`CACHE_ADDR_W-1:0] req_addr;
    logic                     resp_valid;
    logic                     resp_hit;
    word_t                    resp_data;
    logic                     fill;
    logic [`CACHE_ADDR_W-1:0] fill_addr;
    line_t                    fill_line;
    byte_mask_t               fill_mask;
    logic                     inval;
    index_t                   inval_index;

    // reference model with one entry per set
    logic  m_valid [`CACHE_SETS];
    tag_t  m_tag [`CACHE_SETS];
    line_t m_line [`CACHE_SETS];

    integer seed   = 32'h1631_18dd;
    int     errors = 0;
    int     checks = 0;

    cache_top DUT (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .req_addr    (req_addr),
        .resp_valid  (resp_valid),
        .resp_hit    (resp_hit),
        .resp_data   (resp_data),
        .fill        (fill),
        .fill_addr   (fill_addr),
        .fill_line   (fill_line),
        .fill_mask   (fill_mask),
        .inval       (inval),
        .inval_index (inval_index)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // watchdog sized from the test lengths plus margin
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: run still going after %0d ns", TIMEOUT_NS);
        $display("Errors found");
        $finish;
    end

    function automatic logic [31:0] make_addr(input tag_t tag, input index_t idx,
                                              input offset_t off);
        return {tag, idx, off};
    endfunction

    function automatic index_t index_of(input logic [31:0] addr);
        return addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    endfunction

    function automatic tag_t tag_of(input logic [31:0] addr);
        return addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    endfunction

    // hit when the set holds a valid entry with this tag
    function automatic logic model_hit(input logic [31:0] addr);
        return m_valid[index_of(addr)] && (m_tag[index_of(addr)] == tag_of(addr));
    endfunction

    // word picked by offset bits 5:2 with byte bits ignored
    function automatic word_t model_word(input logic [31:0] addr);
        int w;
        w = int'(addr[`CACHE_OFFSET_W-1:2]);
        return m_line[index_of(addr)][w * `CACHE_WORD_W +: `CACHE_WORD_W];
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        errors++;
        $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, got);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Failure at %0t: %s", $time, what);
    endtask

    // data only matters on a hit
    task automatic check_response(input logic [31:0] addr, input logic exp_hit,
                                  input word_t exp_word);
        checks++;
        assert (resp_hit === exp_hit)
            else report_mismatch($sformatf("resp_hit (%h)", addr), 32'(exp_hit), 32'(resp_hit));
        if (exp_hit) begin
            checks++;
            assert (resp_data === exp_word)
                else report_mismatch($sformatf("resp_data (%h)", addr), exp_word, resp_data);
        end
    endtask

    task automatic random_line(output line_t l);
        logic [31:0] rnd;
        for (int w = 0; w < WORDS; w++) begin
            rnd = $random(seed);
            l[w * `CACHE_WORD_W +: `CACHE_WORD_W] = rnd;
        end
    endtask

    task automatic random_mask(output byte_mask_t m);
        logic [31:0] lo;
        logic [31:0] hi;
        lo = $random(seed);
        hi = $random(seed);
        m  = {hi, lo};
    endtask

    // one cycle fill strobe and then a merge into the model
    task automatic issue_fill(input logic [31:0] addr, input line_t line, input byte_mask_t mask);
        index_t idx;
        idx       = index_of(addr);
        fill      = 1'b1;
        fill_addr = addr;
        fill_line = line;
        fill_mask = mask;
        @(negedge clk);
        fill = 1'b0;
        for (int b = 0; b < `CACHE_LINE_BYTES; b++) begin
            if (mask[b]) m_line[idx][b * 8 +: 8] = line[b * 8 +: 8];
        end
        m_valid[idx] = 1'b1;
        m_tag[idx]   = tag_of(addr);
    endtask

    task automatic issue_inval(input index_t idx);
        inval       = 1'b1;
        inval_index = idx;
        @(negedge clk);
        inval        = 1'b0;
        m_valid[idx] = 1'b0;
    endtask

    // single read that waits for resp_valid and checks latency and payload
    task automatic read_and_check(input logic [31:0] addr);
        logic  exp_hit;
        word_t exp_word;
        int    waited;
        exp_hit  = model_hit(addr);
        exp_word = model_word(addr);
        req      = 1'b1;
        req_addr = addr;
        @(negedge clk);
        req    = 1'b0;
        waited = 1;
        while (!resp_valid && waited < RESP_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        checks++;
        assert (resp_valid)
            else report_failure($sformatf("no response to read of %h", addr));
        if (resp_valid) begin
            checks++;
            assert (waited == RESP_DELAY)
                else report_failure($sformatf("read of %h answered after %0d cycles",
                                              addr, waited - 1));
            check_response(addr, exp_hit, exp_word);
        end
    endtask

    task automatic cold_miss();
        logic [31:0] rnd;
        index_t      idx [4];
        $display("test 1, cold miss");
        idx = '{6'd0, 6'd5, 6'd17, 6'd63};
        for (int i = 0; i < 4; i++) begin
            rnd = $random(seed);
            read_and_check(make_addr(rnd[31:12], idx[i], rnd[5:0]));
        end
    endtask

    // byte offset moves inside each word and must not matter
    task automatic full_fill_hit();
        line_t line;
        $display("test 2, full fill then hit");
        random_line(line);
        issue_fill(make_addr(TAG_A, IDX_A, '0), line, '1);
        for (int w = 0; w < WORDS; w++) read_and_check(make_addr(TAG_A, IDX_A, {4'(w), 2'(w)}));
    endtask

    task automatic partial_fill_merge();
        line_t      line;
        byte_mask_t mask;
        $display("test 3, partial fill merge");
        random_line(line);
        random_mask(mask);
        issue_fill(make_addr(TAG_A, IDX_A, '0), line, mask);
        for (int w = 0; w < WORDS; w++) read_and_check(make_addr(TAG_A, IDX_A, {4'(w), 2'b00}));
    endtask

    task automatic tag_conflict();
        line_t line;
        $display("test 4, tag conflict");
        read_and_check(make_addr(TAG_B, IDX_A, '0));
        random_line(line);
        issue_fill(make_addr(TAG_B, IDX_A, '0), line, '1);
        for (int w = 0; w < 4; w++) read_and_check(make_addr(TAG_B, IDX_A, {4'(w * 5), 2'b00}));
        // old tag now evicted
        read_and_check(make_addr(TAG_A, IDX_A, '0));
    endtask

    task automatic invalidate_line();
        line_t line;
        $display("test 5, invalidate");
        random_line(line);
        issue_fill(make_addr(TAG_C, IDX_C, '0), line, '1);
        issue_inval(IDX_A);
        read_and_check(make_addr(TAG_B, IDX_A, 6'd0));
        read_and_check(make_addr(TAG_B, IDX_A, 6'd28));
        // neighbour set untouched
        read_and_check(make_addr(TAG_C, IDX_C, 6'd12));
        read_and_check(make_addr(TAG_C, IDX_C, 6'd48));
    endtask

    // back to back reads with responses matched against a queue
    task automatic pipelined_reads();
        logic [31:0] rnd;
        logic [31:0] addr;
        line_t       line;
        index_t      idx;
        tag_t        tag;
        logic [31:0] addr_q [$];
        logic        hit_q [$];
        word_t       word_q [$];
        int          due_q [$];
        int          due;
        int          cycle;
        int          issued;
        $display("test 6, pipelined reads");
        for (int i = 0; i < 4; i++) begin
            random_line(line);
            rnd = $random(seed);
            issue_fill(make_addr(rnd[31:12], 6'(32 + i), '0), line, '1);
        end
        cycle  = 0;
        issued = 0;
        while ((issued < PIPE_READS || addr_q.size() > 0)
               && cycle < PIPE_READS + RESP_LIMIT) begin
            // outputs settled since the last rising edge
            if (resp_valid) begin
                checks++;
                assert (addr_q.size() > 0)
                    else report_failure("response with no read outstanding");
                if (addr_q.size() > 0) begin
                    addr = addr_q.pop_front();
                    due  = due_q.pop_front();
                    checks++;
                    assert (due == cycle)
                        else report_failure($sformatf("read of %h answered %0d cycles late",
                                                      addr, cycle - due));
                    check_response(addr, hit_q.pop_front(), word_q.pop_front());
                end
            end
            if (issued < PIPE_READS) begin
                rnd  = $random(seed);
                // half the reads go to the freshly filled sets 32..35
                idx  = rnd[8] ? 6'(32 + rnd[1:0]) : rnd[5:0];
                tag  = rnd[9] ? m_tag[idx] : rnd[31:12];
                addr = make_addr(tag, idx, rnd[15:10]);
                addr_q.push_back(addr);
                hit_q.push_back(model_hit(addr));
                word_q.push_back(model_word(addr));
                due_q.push_back(cycle + RESP_DELAY);
                req      = 1'b1;
                req_addr = addr;
                issued++;
            end else begin
                req = 1'b0;
            end
            @(negedge clk);
            cycle++;
        end
        req = 1'b0;
        checks++;
        assert (addr_q.size() == 0)
            else report_failure($sformatf("%0d reads never answered", addr_q.size()));
    endtask

    initial begin
        reset       = 1'b1;
        req         = 1'b0;
        req_addr    = '0;
        fill        = 1'b0;
        fill_addr   = '0;
        fill_line   = '0;
        fill_mask   = '0;
        inval       = 1'b0;
        inval_index = '0;
        // rams start zeroed and so does the model
        for (int i = 0; i < `CACHE_SETS; i++) begin
            m_valid[i] = 1'b0;
            m_tag[i]   = '0;
            m_line[i]  = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        cold_miss();
        full_fill_hit();
        partial_fill_merge();
        tag_conflict();
        invalidate_line();
        pipelined_reads();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/cache_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_defs.svh"

// direct mapped cache lookup path
// request stage -> tag and data rams -> hit checker
// read answered two cycles after req, no stalls
module cache_top import cache_pkg::*; (
    input  wire                       clk,
    input  wire                       reset,
    // cpu side
    input  wire                       req,
    input  wire [`CACHE_ADDR_W-1:0]   req_addr,
    output logic                      resp_valid,
    output logic                      resp_hit,
    output word_t                     resp_data,
    // memory side
    input  wire                       fill,
    input  wire [`CACHE_ADDR_W-1:0]   fill_addr,
    input  wire line_t                fill_line,
    input  wire byte_mask_t           fill_mask,
    input  wire                       inval,
    input  wire index_t               inval_index
);

    // tag ram port
    logic       tag_en;
    logic       tag_we;
    index_t     tag_addr;
    tag_entry_t tag_wdata;
    tag_entry_t tag_rdata;

    // data ram port
    logic       data_en;
    byte_mask_t data_we;
    index_t     data_addr;
    line_t      data_wdata;
    line_t      data_rdata;

    // request stage to hit checker
    logic    lookup;
    tag_t    lookup_tag;
    offset_t lookup_offset;

    // producer
    req_stage u_req_stage (
        .clk           (clk),
        .reset         (reset),
        .req           (req),
        .req_addr      (req_addr),
        .fill          (fill),
        .fill_addr     (fill_addr),
        .fill_line     (fill_line),
        .fill_mask     (fill_mask),
        .inval         (inval),
        .inval_index   (inval_index),
        .tag_en        (tag_en),
        .tag_we        (tag_we),
        .tag_addr      (tag_addr),
        .tag_wdata     (tag_wdata),
        .data_en       (data_en),
        .data_we       (data_we),
        .data_addr     (data_addr),
        .data_wdata    (data_wdata),
        .lookup        (lookup),
        .lookup_tag    (lookup_tag),
        .lookup_offset (lookup_offset)
    );

    // valid + tag per set, written whole
    sync_ram #(
        .payload_t (tag_entry_t),
        .LANES     (1),
        .DEPTH     (`CACHE_SETS)
    ) u_tag_ram (
        .clk   (clk),
        .en    (tag_en),
        .we    (tag_we),
        .addr  (tag_addr),
        .wdata (tag_wdata),
        .rdata (tag_rdata)
    );

    // line data per set, byte lanes for partial fills
    sync_ram #(
        .payload_t (line_t),
        .LANES     (`CACHE_LINE_BYTES),
        .DEPTH     (`CACHE_SETS)
    ) u_data_ram (
        .clk   (clk),
        .en    (data_en),
        .we    (data_we),
        .addr  (data_addr),
        .wdata (data_wdata),
        .rdata (data_rdata)
    );

    // consumer
    hit_check u_hit_check (
        .clk           (clk),
        .reset         (reset),
        .lookup        (lookup),
        .lookup_tag    (lookup_tag),
        .lookup_offset (lookup_offset),
        .tag_rdata     (tag_rdata),
        .data_rdata    (data_rdata),
        .resp_valid    (resp_valid),
        .resp_hit      (resp_hit),
        .resp_data     (resp_data)
    );

endmodule

`default_nettype wire

//--- design/hit_check.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_defs.svh"

// hit checker as the consumer of the two ram outputs
// compares tag entry, picks the word, registers the response
module hit_check import cache_pkg::*; (
    input  wire              clk,
    input  wire              reset,
    // delayed request from the request stage
    input  wire              lookup,
    input  wire tag_t        lookup_tag,
    input  wire offset_t     lookup_offset,
    // ram read data for the same request
    input  wire tag_entry_t  tag_rdata,
    input  wire line_t       data_rdata,
    // response to the cpu
    output logic             resp_valid,
    output logic             resp_hit,
    output word_t            resp_data
);

    // words in a line and bits to select one
    localparam int WORDS = (`CACHE_LINE_BYTES * 8) / `CACHE_WORD_W;
    localparam int SEL_W = $clog2(WORDS);

    logic             hit;
    logic [SEL_W-1:0] word_idx;
    word_t            word_sel;

    // upper offset bits pick the word
    // low two bits are the byte inside it
    assign word_idx = lookup_offset[`CACHE_OFFSET_W-1 -: SEL_W];

    // valid entry with a matching tag
    assign hit = tag_rdata.valid && (tag_rdata.tag == lookup_tag);

    assign word_sel = data_rdata[int'(word_idx) * `CACHE_WORD_W +: `CACHE_WORD_W];

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= lookup;
        end
    end

    // response payload
    // word goes out on a miss too and the cpu ignores it then
    always_ff @(posedge clk) begin
        if (lookup) begin
            resp_hit  <= hit;
            resp_data <= word_sel;
        end
    end

    // lookup must meet a tag entry that the ram has actually read out
    a_entry_read: assert property (@(posedge clk) disable iff (reset)
        lookup |-> !$isunknown(tag_rdata))
        else $error("hit_check: lookup met a tag entry that was never read");

endmodule

`default_nettype wire

//--- design/req_stage.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_defs.svh"

// request stage, the producer side of the lookup path
// takes one command per cycle, drives both rams one edge later
module req_stage import cache_pkg::*; (
    input  wire                       clk,
    input  wire                       reset,
    // cpu read requests
    input  wire                       req,
    input  wire [`CACHE_ADDR_W-1:0]   req_addr,
    // line fills from memory
    input  wire                       fill,
    input  wire [`CACHE_ADDR_W-1:0]   fill_addr,
    input  wire line_t                fill_line,
    input  wire byte_mask_t           fill_mask,
    // invalidate one set
    input  wire                       inval,
    input  wire index_t               inval_index,
    // tag ram port
    output logic                      tag_en,
    output logic                      tag_we,
    output index_t                    tag_addr,
    output tag_entry_t                tag_wdata,
    // data ram port
    output logic                      data_en,
    output byte_mask_t                data_we,
    output index_t                    data_addr,
    output line_t                     data_wdata,
    // to the hit checker, aligned with ram read data
    output logic                      lookup,
    output tag_t                      lookup_tag,
    output offset_t                   lookup_offset
);

    // tag sits above index and offset
    localparam int TAG_LSB = `CACHE_OFFSET_W + `CACHE_INDEX_W;

    // command strobes, one edge after the ports
    logic req_q;
    logic fill_q;
    logic inval_q;

    // command payload
    index_t     cmd_index;
    tag_t       cmd_tag;
    index_t     index_q;
    tag_t       tag_q;
    offset_t    offset_q;
    line_t      line_q;
    byte_mask_t mask_q;

    // pick the index and tag of whichever strobe is up
    always_comb begin
        if (fill) begin
            cmd_index = fill_addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
            cmd_tag   = fill_addr[TAG_LSB +: `CACHE_TAG_W];
        end else if (inval) begin
            cmd_index = inval_index;
            // tag is don't care, entry goes invalid
            cmd_tag   = req_addr[TAG_LSB +: `CACHE_TAG_W];
        end else begin
            cmd_index = req_addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
            cmd_tag   = req_addr[TAG_LSB +: `CACHE_TAG_W];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            req_q   <= 1'b0;
            fill_q  <= 1'b0;
            inval_q <= 1'b0;
            lookup  <= 1'b0;
        end else begin
            req_q   <= req;
            fill_q  <= fill;
            inval_q <= inval;
            // lookup trails the ram enable so it meets rdata
            lookup  <= req_q;
        end
    end

    always_ff @(posedge clk) begin
        index_q       <= cmd_index;
        tag_q         <= cmd_tag;
        offset_q      <= req_addr[`CACHE_OFFSET_W-1:0];
        lookup_tag    <= tag_q;
        lookup_offset <= offset_q;
        // wide fill payload only moves on a fill
        if (fill) begin
            line_q <= fill_line;
            mask_q <= fill_mask;
        end
    end

    // tag ram, any command touches it
    assign tag_en          = req_q | fill_q | inval_q;
    assign tag_we          = fill_q | inval_q;
    assign tag_addr        = index_q;
    assign tag_wdata.valid = fill_q;
    assign tag_wdata.tag   = tag_q;

    // data ram, idle on invalidate
    assign data_en    = req_q | fill_q;
    assign data_we    = {`CACHE_LINE_BYTES{fill_q}} & mask_q;
    assign data_addr  = index_q;
    assign data_wdata = line_q;

    // one command per cycle, nothing arbitrates between them
    a_one_cmd: assert property (@(posedge clk) disable iff (reset)
        $onehot0({req, fill, inval}))
        else $error("req_stage: req, fill and inval overlap");

endmodule

`default_nettype wire

//--- design/sync_ram.sv
`timescale 1ns/100ps
`default_nettype none

// single port ram, one read or write per enabled edge
// payload is cut into LANES equal slices with their own write enable
module sync_ram import cache_pkg::*; #(
    parameter type payload_t = tag_entry_t,
    parameter int  LANES     = 1,
    parameter int  DEPTH     = 64
) (
    input  wire           clk,
    input  wire           en,
    input  wire [LANES-1:0] we,
    input  wire index_t   addr,
    input  wire payload_t wdata,
    output payload_t      rdata
);

    // flat view of the payload
    localparam int W  = $bits(payload_t);
    // bits per write lane
    localparam int LW = W / LANES;

    // storage, zero from time zero, never swept by reset
    logic [W-1:0] mem [DEPTH] = '{default: '0};

    logic [W-1:0] wdata_bits;
    logic [W-1:0] stored;
    logic [W-1:0] merged;
    logic [W-1:0] rdata_bits;

    assign wdata_bits = wdata;
    assign stored     = mem[addr];

    // write first per lane
    // written lanes return new data, others return the stored line
    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            merged[k*LW +: LW] = we[k] ? wdata_bits[k*LW +: LW] : stored[k*LW +: LW];
        end
    end

    // lane writes, only under their own enable
    always @(posedge clk) begin
        if (en) begin
            for (int k = 0; k < LANES; k++) begin
                if (we[k]) begin
                    mem[addr][k*LW +: LW] <= wdata_bits[k*LW +: LW];
                end
            end
        end
    end

    // read register, holds its value while idle
    always_ff @(posedge clk) begin
        if (en) begin
            rdata_bits <= merged;
        end
    end

    assign rdata = payload_t'(rdata_bits);

    // lanes must tile the payload exactly or the top bits go unwritten
    a_lane_split: assert property (@(posedge clk) (W % LANES) == 0)
        else $error("sync_ram: payload of %0d bits does not split into %0d lanes", W, LANES);

endmodule

`default_nettype wire

//--- design/cache_pkg.sv
`default_nettype none

package cache_pkg;

    `include "cache_defs.svh"

    // address fields
    typedef logic [`CACHE_TAG_W-1:0] tag_t;
    typedef logic [`CACHE_INDEX_W-1:0] index_t;
    typedef logic [`CACHE_OFFSET_W-1:0] offset_t;

    // one tag store entry, valid on top of the tag
    // 21 bits in total
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    // full cache line, byte 0 in the low bits
    typedef logic [`CACHE_LINE_BYTES*8-1:0] line_t;

    // one write enable per line byte
    typedef logic [`CACHE_LINE_BYTES-1:0] byte_mask_t;

    // response word
    typedef logic [`CACHE_WORD_W-1:0] word_t;

endpackage

`default_nettype wire

//--- design/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// byte address width on the cpu and memory ports
`define CACHE_ADDR_W 32

// address split, tag | index | offset
`define CACHE_OFFSET_W 6
`define CACHE_INDEX_W 6
`define CACHE_TAG_W 20

// direct mapped geometry
`define CACHE_SETS 64
`define CACHE_LINE_BYTES 64

// word handed back on a read response
`define CACHE_WORD_W 32

`endif
